// File: tb.f
adpcmb_pkg.sv
adpcmb_seq_if.sv
adpcmb_cen.sv
adpcmb_cnt.sv
adpcmb_decoder.sv
adpcmb_interpol.sv
adpcmb_gain.sv
adpcmb_drv.sv
adpcmb_top.sv
tb_adpcmb.sv

// File: tb_adpcmb.sv
// ------------------------------------------------------------
// directed testbench for the ADPCM-B playback channel
// byte memory model with random fill, shared by two DUTs
// reference decoder, gain and pan model checked per fetch
// reset state, fetch order, end flag, repeat, channel reset
// ------------------------------------------------------------
module tb_adpcmb;

    localparam int CLK_PERIOD = 40;
    localparam int SEED       = 59132;

    logic               clk;
    logic               arst_n;
    logic               key_on;
    logic               repeat_en;
    logic               chan_rst;
    logic [1:0]         pan;
    adpcmb_pkg::page_t  start_page;
    adpcmb_pkg::page_t  end_page;
    adpcmb_pkg::delta_t delta_n;
    adpcmb_pkg::tl_t    tl;
    logic               clr_flag;
    logic [7:0]         mem_data;     // to the plain instance
    logic [7:0]         mem_data_ip;  // to the interpolating instance
    adpcmb_pkg::addr_t  mem_addr;
    adpcmb_pkg::addr_t  mem_addr_ip;
    logic               mem_oe_n;
    logic               mem_oe_n_ip;
    logic               flag;
    logic               flag_ip;
    adpcmb_pkg::pcm_t   pcm_l;
    adpcmb_pkg::pcm_t   pcm_r;
    adpcmb_pkg::pcm_t   pcm_l_ip;
    adpcmb_pkg::pcm_t   pcm_r_ip;

    logic [7:0] mem [65536];  // sample memory
    int         errors;
    int         timeouts;
    int         reads;        // strobes since the last key on
    int         ref_pcm;      // reference decoder state
    int         ref_step;
    int         hist [$];     // scaled reference sample per read

    assign mem_data    = mem[mem_addr[15:0]];     // answers within the strobe
    assign mem_data_ip = mem[mem_addr_ip[15:0]];

    adpcmb_top #(.CEN_DIV(2), .CEN55_DIV(8), .INTERPOL(0)) adpcmb_top_inst (
        .clk (clk), .arst_n (arst_n), .key_on (key_on), .repeat_en (repeat_en),
        .chan_rst (chan_rst), .pan (pan), .start_page (start_page),
        .end_page (end_page), .delta_n (delta_n), .tl (tl), .clr_flag (clr_flag),
        .mem_data (mem_data), .mem_addr (mem_addr), .mem_oe_n (mem_oe_n),
        .flag (flag), .pcm_l (pcm_l), .pcm_r (pcm_r)
    );

    adpcmb_top #(.CEN_DIV(2), .CEN55_DIV(8), .INTERPOL(1)) adpcmb_top_interp_inst (
        .clk (clk), .arst_n (arst_n), .key_on (key_on), .repeat_en (repeat_en),
        .chan_rst (chan_rst), .pan (pan), .start_page (start_page),
        .end_page (end_page), .delta_n (delta_n), .tl (tl), .clr_flag (clr_flag),
        .mem_data (mem_data_ip), .mem_addr (mem_addr_ip), .mem_oe_n (mem_oe_n_ip),
        .flag (flag_ip), .pcm_l (pcm_l_ip), .pcm_r (pcm_r_ip)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic check_equal(input string msg, input int actual, input int expected);
        if (actual !== expected) begin
            errors++;
            $display("CHECK FAILED at %0t: %s, got %0d, expected %0d",
                     $time, msg, actual, expected);
        end
    endtask

    function automatic int clamp(input int v, input int lo, input int hi);
        if (v < lo) return lo;
        if (v > hi) return hi;
        return v;
    endfunction

    // adaptive step rule, one nibble
    task automatic decode_reference(input logic [3:0] nib);
        int mag;
        int diff;
        mag      = int'(nib[2:0]);
        diff     = ((2 * mag + 1) * ref_step) / 8;  // operands positive, floor
        ref_pcm  = nib[3] ? ref_pcm - diff : ref_pcm + diff;
        ref_pcm  = clamp(ref_pcm, -32768, 32767);
        ref_step = (ref_step * int'(adpcmb_pkg::step_scale[mag])) / 64;
        ref_step = clamp(ref_step, int'(adpcmb_pkg::STEP_MIN), int'(adpcmb_pkg::STEP_MAX));
    endtask

    // tl gain, arithmetic shift floors negatives
    function automatic int scale_by_level(input int s);
        return (s * int'(tl)) >>> 8;
    endfunction

    // fetch monitor, every strobe checks address and output samples
    always @(negedge clk) begin : strobe_monitor
        int         span;
        int         exp_addr;
        int         lo;
        int         hi;
        int         ip;
        logic [3:0] nib;
        if (arst_n && !mem_oe_n) begin
            span     = (int'(end_page) - int'(start_page) + 1) * 256;
            exp_addr = int'(start_page) * 256 + (reads / 2) % span;  // wraps on repeat
            check_equal("fetch address", int'(mem_addr), exp_addr);
            check_equal("interpolating instance strobe", int'(mem_oe_n_ip), 0);
            check_equal("interpolating instance address", int'(mem_addr_ip), exp_addr);
            nib = reads[0] ? mem[exp_addr][3:0] : mem[exp_addr][7:4];  // high first
            decode_reference(nib);
            hist.push_back(scale_by_level(ref_pcm));
            if (reads >= 2) begin  // two ticks of output latency
                check_equal("pcm_l", int'(pcm_l), pan[1] ? hist[reads - 2] : 0);
                check_equal("pcm_r", int'(pcm_r), pan[0] ? hist[reads - 2] : 0);
            end
            if (reads >= 4) begin
                lo = (hist[reads - 4] < hist[reads - 3]) ? hist[reads - 4] : hist[reads - 3];
                hi = (hist[reads - 4] < hist[reads - 3]) ? hist[reads - 3] : hist[reads - 4];
                ip = pan[1] ? int'(pcm_l_ip) : int'(pcm_r_ip);
                check_equal("interpolated sample in range", (ip >= lo && ip <= hi) ? 1 : 0, 1);
            end
            reads++;
        end
    end

    task automatic wait_for_reads(input int target, input int max_clks);
        int cycles;
        cycles = 0;
        while (reads < target && cycles < max_clks) begin
            @(negedge clk);
            cycles++;
        end
        if (reads < target) begin
            timeouts++;
            $display("timeout: only %0d of %0d memory reads arrived", reads, target);
        end
    endtask

    task automatic wait_for_flag(input logic level, input int max_clks);
        int cycles;
        cycles = 0;
        while (flag !== level && cycles < max_clks) begin
            @(negedge clk);
            cycles++;
        end
        if (flag !== level) begin
            timeouts++;
            $display("timeout: flag never went to %0d", level);
        end
    endtask

    // program the channel, clear the model, pulse key on for over a tick
    task automatic start_playback(input adpcmb_pkg::page_t s, input adpcmb_pkg::page_t e,
                                  input logic rep, input logic [1:0] p,
                                  input adpcmb_pkg::tl_t level);
        start_page = s;
        end_page   = e;
        repeat_en  = rep;
        pan        = p;
        tl         = level;
        delta_n    = 16'hffff;  // one fetch per tick
        reads      = 0;
        ref_pcm    = 0;
        ref_step   = int'(adpcmb_pkg::STEP_MIN);
        hist.delete();
        key_on     = 1'b1;
        repeat (20) @(negedge clk);
        key_on     = 1'b0;
    endtask

    task automatic stop_channel();
        chan_rst = 1'b1;
        @(negedge clk);
        chan_rst = 1'b0;
        @(negedge clk);  // a strobe in flight has ended here
    endtask

    task automatic check_reset_state();
        check_equal("flag after reset", int'(flag), 0);
        check_equal("mem_oe_n after reset", int'(mem_oe_n), 1);
        check_equal("pcm_l after reset", int'(pcm_l), 0);
        check_equal("pcm_r after reset", int'(pcm_r), 0);
        check_equal("interp flag after reset", int'(flag_ip), 0);
        check_equal("interp pcm_l after reset", int'(pcm_l_ip), 0);
    endtask

    // two pages, no repeat, then flag clear
    task automatic play_to_end();
        start_playback(16'd2, 16'd3, 1'b0, 2'b10, 8'hff);
        wait_for_flag(1'b1, 20000);
        repeat (64) @(negedge clk);
        check_equal("reads up to the end page", reads, 1024);
        repeat (160) @(negedge clk);
        check_equal("reads after the end", reads, 1024);
        check_equal("flag held", int'(flag), 1);
        check_equal("interp flag held", int'(flag_ip), 1);
        clr_flag = 1'b1;
        @(negedge clk);
        clr_flag = 1'b0;
        @(negedge clk);
        check_equal("flag after clear", int'(flag), 0);
        check_equal("interp flag after clear", int'(flag_ip), 0);
    endtask

    // one page looping, right side only
    task automatic loop_sample();
        start_playback(16'd4, 16'd4, 1'b1, 2'b01, 8'h80);
        wait_for_reads(520, 10000);  // past the wrap
        check_equal("flag while looping", int'(flag), 0);
        stop_channel();
    endtask

    task automatic restart_after_reset();
        int count;
        start_playback(16'd2, 16'd2, 1'b0, 2'b11, 8'($urandom_range(255, 1)));
        wait_for_reads(40, 2000);
        stop_channel();
        count = reads;
        repeat (100) @(negedge clk);
        check_equal("reads after channel reset", reads, count);
        start_playback(16'd2, 16'd2, 1'b0, 2'b11, tl);  // decoder starts clean
        wait_for_reads(24, 2000);
        stop_channel();
    endtask

    initial begin
        errors     = 0;
        timeouts   = 0;
        reads      = 0;
        ref_pcm    = 0;
        ref_step   = int'(adpcmb_pkg::STEP_MIN);
        arst_n     = 1'b0;
        key_on     = 1'b0;
        repeat_en  = 1'b0;
        chan_rst   = 1'b0;
        pan        = 2'b11;
        start_page = '0;
        end_page   = '0;
        delta_n    = '0;
        tl         = '0;
        clr_flag   = 1'b0;
        void'($urandom(SEED));
        for (int i = 0; i < 65536; i++) begin
            mem[i] = 8'($urandom());
        end
        repeat (2) @(negedge clk);
        arst_n = 1'b1;
        repeat (4) @(negedge clk);
        check_reset_state();
        if (timeouts == 0) play_to_end();
        if (timeouts == 0) loop_sample();
        if (timeouts == 0) restart_after_reset();
        $display("check errors: %0d, timeouts: %0d", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: adpcmb_top.sv
// ------------------------------------------------------------
// ADPCM-B playback channel top level
// clock enable divider and channel driver
// ------------------------------------------------------------
module adpcmb_top #(
    parameter int CEN_DIV   = 2,
    parameter int CEN55_DIV = 8,
    parameter int INTERPOL  = 1
) (
    input  logic               clk,
    input  logic               arst_n,
    input  logic               key_on,
    input  logic               repeat_en,
    input  logic               chan_rst,
    input  logic [1:0]         pan,
    input  adpcmb_pkg::page_t  start_page,
    input  adpcmb_pkg::page_t  end_page,
    input  adpcmb_pkg::delta_t delta_n,
    input  adpcmb_pkg::tl_t    tl,
    input  logic               clr_flag,
    input  logic [7:0]         mem_data,
    output adpcmb_pkg::addr_t  mem_addr,
    output logic               mem_oe_n,
    output logic               flag,
    output adpcmb_pkg::pcm_t   pcm_l,
    output adpcmb_pkg::pcm_t   pcm_r
);

    logic cen;
    logic cen55;  // sample rate tick

    adpcmb_cen #(
        .CEN_DIV   (CEN_DIV),
        .CEN55_DIV (CEN55_DIV)
    ) adpcmb_cen_inst (
        .clk    (clk),
        .arst_n (arst_n),
        .cen    (cen),
        .cen55  (cen55)
    );

    adpcmb_drv #(
        .INTERPOL (INTERPOL)
    ) adpcmb_drv_inst (
        .clk        (clk),
        .arst_n     (arst_n),
        .cen        (cen),
        .cen55      (cen55),
        .key_on     (key_on),
        .repeat_en  (repeat_en),
        .chan_rst   (chan_rst),
        .pan        (pan),
        .start_page (start_page),
        .end_page   (end_page),
        .delta_n    (delta_n),
        .tl         (tl),
        .clr_flag   (clr_flag),
        .mem_addr   (mem_addr),
        .mem_data   (mem_data),
        .mem_oe_n   (mem_oe_n),
        .flag       (flag),
        .pcm_l      (pcm_l),
        .pcm_r      (pcm_r)
    );

endmodule

// File: adpcmb_drv.sv
// ------------------------------------------------------------
// ADPCM-B channel driver
// sequencer, memory strobe and nibble select
// decoder, interpolator and gain chain
// left/right panning on cen55
// ------------------------------------------------------------
module adpcmb_drv #(
    parameter int INTERPOL = 1
) (
    input  logic               clk,
    input  logic               arst_n,
    input  logic               cen,
    input  logic               cen55,
    input  logic               key_on,
    input  logic               repeat_en,
    input  logic               chan_rst,
    input  logic [1:0]         pan,         // bit 1 left, bit 0 right
    input  adpcmb_pkg::page_t  start_page,
    input  adpcmb_pkg::page_t  end_page,
    input  adpcmb_pkg::delta_t delta_n,
    input  adpcmb_pkg::tl_t    tl,
    input  logic               clr_flag,
    output adpcmb_pkg::addr_t  mem_addr,
    input  logic [7:0]         mem_data,
    output logic               mem_oe_n,
    output logic               flag,
    output adpcmb_pkg::pcm_t   pcm_l,
    output adpcmb_pkg::pcm_t   pcm_r
);

    adpcmb_seq_if seq ();

    logic                sel_q;    // nibble select of the pending read
    logic                din_vld;  // din just loaded
    logic                key_q;
    logic                dec_clr;
    adpcmb_pkg::nibble_t din;
    adpcmb_pkg::pcm_t    pcm_dec;
    adpcmb_pkg::pcm_t    pcm_int;
    adpcmb_pkg::pcm_t    pcm_gain;

    adpcmb_cnt adpcmb_cnt_inst (
        .clk        (clk),
        .arst_n     (arst_n),
        .cen55      (cen55),
        .key_on     (key_on),
        .repeat_en  (repeat_en),
        .chan_rst   (chan_rst),
        .start_page (start_page),
        .end_page   (end_page),
        .delta_n    (delta_n),
        .clr_flag   (clr_flag),
        .flag       (flag),
        .seq        (seq)
    );

    // fresh decoder on every key on and on channel reset
    assign dec_clr = chan_rst | (key_on & ~key_q);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            mem_oe_n <= 1'b1;
            din_vld  <= 1'b0;
            key_q    <= 1'b0;
        end else begin
            mem_oe_n <= ~(seq.adv & cen55 & ~chan_rst);  // one clk per fetch
            din_vld  <= ~mem_oe_n;
            key_q    <= key_on;
        end
    end

    // address held for the read, the counter moves on meanwhile
    always_ff @(posedge clk) begin
        if (seq.adv && cen55) begin
            mem_addr <= seq.addr;
            sel_q    <= seq.nibble_sel;
        end
        if (!mem_oe_n) begin
            din <= sel_q ? mem_data[3:0] : mem_data[7:4];  // high nibble first
        end
    end

    adpcmb_decoder adpcmb_decoder_inst (
        .clk    (clk),
        .arst_n (arst_n),
        .cen    (cen),
        .adv    (din_vld),
        .data   (din),
        .clr    (dec_clr),
        .pcm    (pcm_dec)
    );

    adpcmb_interpol #(
        .INTERPOL (INTERPOL)
    ) adpcmb_interpol_inst (
        .clk        (clk),
        .arst_n     (arst_n),
        .cen55      (cen55),
        .adv        (seq.adv),
        .phase_frac (seq.phase_frac),
        .pcm_in     (pcm_dec),
        .pcm_out    (pcm_int)
    );

    adpcmb_gain adpcmb_gain_inst (
        .clk     (clk),
        .arst_n  (arst_n),
        .cen55   (cen55),
        .tl      (tl),
        .pcm_in  (pcm_int),
        .pcm_out (pcm_gain)
    );

    // panning, a disabled side is silent
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pcm_l <= '0;
            pcm_r <= '0;
        end else if (cen55) begin
            pcm_l <= pan[1] ? pcm_gain : '0;
            pcm_r <= pan[0] ? pcm_gain : '0;
        end
    end

endmodule

// File: adpcmb_gain.sv
// ------------------------------------------------------------
// total level gain stage
// out = in * tl / 256, floor rounding, updated on cen55
// ------------------------------------------------------------
module adpcmb_gain (
    input  logic             clk,
    input  logic             arst_n,
    input  logic             cen55,
    input  adpcmb_pkg::tl_t  tl,
    input  adpcmb_pkg::pcm_t pcm_in,
    output adpcmb_pkg::pcm_t pcm_out
);

    logic signed [24:0] prod;  // 16 x 9 bit signed

    assign prod = pcm_in * $signed({1'b0, tl});  // tl is unsigned

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pcm_out <= '0;
        end else if (cen55) begin
            pcm_out <= prod[23:8];  // dropping low bits rounds down
        end
    end

endmodule

// File: adpcmb_interpol.sv
// ------------------------------------------------------------
// linear interpolation between decoded samples
// previous/current pair shifted on each fetch
// weight from the top byte of the phase accumulator
// INTERPOL = 0 passes the decoder output through
// ------------------------------------------------------------
module adpcmb_interpol #(
    parameter int INTERPOL = 1
) (
    input  logic             clk,
    input  logic             arst_n,
    input  logic             cen55,
    input  logic             adv,
    input  logic [7:0]       phase_frac,
    input  adpcmb_pkg::pcm_t pcm_in,
    output adpcmb_pkg::pcm_t pcm_out
);

    adpcmb_pkg::pcm_t   prev;
    adpcmb_pkg::pcm_t   cur;
    logic signed [16:0] delta;   // cur - prev, full range
    logic signed [25:0] scaled;  // delta * frac
    adpcmb_pkg::pcm_t   lerp;

    // shift on a fetch tick, pcm_in holds the last finished sample
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            prev <= '0;
            cur  <= '0;
        end else if (cen55 && adv) begin
            prev <= cur;
            cur  <= pcm_in;
        end
    end

    assign delta  = $signed({cur[15], cur}) - $signed({prev[15], prev});
    assign scaled = delta * $signed({1'b0, phase_frac});

    // wraps in 16 bits but the true result always lies in range
    assign lerp = prev + scaled[23:8];

    // frac < 256 keeps the result between prev and cur
    assign pcm_out = (INTERPOL != 0) ? lerp : pcm_in;

endmodule

// File: adpcmb_decoder.sv
// ------------------------------------------------------------
// adaptive-step ADPCM nibble decoder
// two cen-paced stages after each new nibble
// difference and step product, then accumulate and clamp
// ------------------------------------------------------------
module adpcmb_decoder (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                cen,
    input  logic                adv,   // new nibble on data
    input  adpcmb_pkg::nibble_t data,
    input  logic                clr,   // back to silence
    output adpcmb_pkg::pcm_t    pcm
);

    typedef enum logic [1:0] {
        DEC_IDLE,
        DEC_MUL,  // products from code and step
        DEC_ACC   // update sample and step
    } dec_state_e;

    dec_state_e          st;
    adpcmb_pkg::nibble_t code;
    adpcmb_pkg::step_t   step;
    logic [19:0]         diff_full;  // (2*mag+1) * step
    logic [23:0]         step_full;  // step * scale
    logic [16:0]         diff;       // diff_full / 8
    logic [17:0]         step_nx;    // step_full / 64, before clamp
    logic signed [17:0]  sum;
    adpcmb_pkg::pcm_t    pcm_nx;
    adpcmb_pkg::step_t   step_cl;

    assign diff_full = {code[2:0], 1'b1} * step;
    assign step_full = step * adpcmb_pkg::step_scale[code[2:0]];

    always_comb begin
        // sign bit picks direction, headroom of two bits
        if (code[3]) begin
            sum = $signed({{2{pcm[15]}}, pcm}) - $signed({1'b0, diff});
        end else begin
            sum = $signed({{2{pcm[15]}}, pcm}) + $signed({1'b0, diff});
        end
        if (sum > 18'sd32767) begin
            pcm_nx = adpcmb_pkg::PCM_MAX;
        end else if (sum < -18'sd32768) begin
            pcm_nx = adpcmb_pkg::PCM_MIN;
        end else begin
            pcm_nx = sum[15:0];
        end
        if (step_nx > 18'(adpcmb_pkg::STEP_MAX)) begin
            step_cl = adpcmb_pkg::STEP_MAX;
        end else if (step_nx < 18'(adpcmb_pkg::STEP_MIN)) begin
            step_cl = adpcmb_pkg::STEP_MIN;
        end else begin
            step_cl = step_nx[15:0];
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            st   <= DEC_IDLE;
            pcm  <= '0;
            step <= adpcmb_pkg::STEP_MIN;
        end else if (clr) begin
            st   <= DEC_IDLE;
            pcm  <= '0;
            step <= adpcmb_pkg::STEP_MIN;
        end else if (adv) begin
            st <= DEC_MUL;  // adv need not line up with cen
        end else if (cen) begin
            case (st)
                DEC_MUL: st <= DEC_ACC;
                DEC_ACC: begin
                    pcm  <= pcm_nx;
                    step <= step_cl;
                    st   <= DEC_IDLE;
                end
                default: st <= DEC_IDLE;
            endcase
        end
    end

    // intermediate products
    always_ff @(posedge clk) begin
        if (adv) begin
            code <= data;
        end
        if (cen && st == DEC_MUL) begin
            diff    <= diff_full[19:3];
            step_nx <= step_full[23:6];
        end
    end

endmodule

// File: adpcmb_cnt.sv
// ------------------------------------------------------------
// playback sequencer
// key-on edge detect and idle/play/done state machine
// delta-N phase accumulator, address and nibble counter
// end page repeat or stop, end-of-sample flag
// ------------------------------------------------------------
module adpcmb_cnt (
    input  logic               clk,
    input  logic               arst_n,
    input  logic               cen55,
    input  logic               key_on,
    input  logic               repeat_en,
    input  logic               chan_rst,
    input  adpcmb_pkg::page_t  start_page,
    input  adpcmb_pkg::page_t  end_page,
    input  adpcmb_pkg::delta_t delta_n,
    input  logic               clr_flag,
    output logic               flag,
    adpcmb_seq_if.cnt          seq
);

    adpcmb_pkg::cnt_state_e state;
    adpcmb_pkg::delta_t     phase;
    adpcmb_pkg::addr_t      addr;
    logic                   nibble_sel;
    logic                   key_q;      // key_on as seen on the last tick
    logic [16:0]            phase_sum;  // bit 16 is the carry
    logic                   key_rise;
    logic                   last_byte;
    logic                   stop;

    assign phase_sum = {1'b0, phase} + {1'b0, delta_n};
    assign key_rise  = key_on & ~key_q;
    assign last_byte = (addr == {end_page, 8'hff});  // last byte of end page

    // low nibble of the last byte consumed, no repeat
    assign stop = cen55 & ~chan_rst & seq.adv & nibble_sel
                & last_byte & ~repeat_en;

    // a restart tick fetches nothing
    assign seq.adv        = (state == adpcmb_pkg::PLAY) & phase_sum[16] & ~key_rise;
    assign seq.nibble_sel = nibble_sel;
    assign seq.addr       = addr;
    assign seq.phase_frac = phase[15:8];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state      <= adpcmb_pkg::IDLE;
            phase      <= '0;
            addr       <= '0;
            nibble_sel <= 1'b0;
            key_q      <= 1'b0;
        end else if (chan_rst) begin
            state <= adpcmb_pkg::IDLE;  // does not wait for a tick
        end else if (cen55) begin
            key_q <= key_on;
            if (key_rise) begin  // (re)start from the first byte
                state      <= adpcmb_pkg::PLAY;
                phase      <= '0;
                addr       <= {start_page, 8'h00};
                nibble_sel <= 1'b0;
            end else if (state == adpcmb_pkg::PLAY) begin
                phase <= phase_sum[15:0];
                if (seq.adv) begin
                    nibble_sel <= ~nibble_sel;  // high then low
                    if (nibble_sel) begin       // byte fully used
                        if (!last_byte) begin
                            addr <= addr + 1'b1;
                        end else if (repeat_en) begin
                            addr <= {start_page, 8'h00};  // loop
                        end else begin
                            state <= adpcmb_pkg::DONE;
                        end
                    end
                end
            end
        end
    end

    // flag holds until cleared
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            flag <= 1'b0;
        end else if (clr_flag) begin
            flag <= 1'b0;
        end else if (stop) begin
            flag <= 1'b1;
        end
    end

    // the end page check must stop or wrap the address in time
    a_addr_in_range: assert property (@(posedge clk) disable iff (!arst_n)
        (state == adpcmb_pkg::PLAY) |-> (addr <= {end_page, 8'hff}));

endmodule

// File: adpcmb_cen.sv
// ------------------------------------------------------------
// clock enable divider
// cen pulses once every CEN_DIV clocks
// cen55 pulses with a cen, once every CEN55_DIV cens
// ------------------------------------------------------------
module adpcmb_cen #(
    parameter int CEN_DIV   = 2,
    parameter int CEN55_DIV = 8
) (
    input  logic clk,
    input  logic arst_n,
    output logic cen,
    output logic cen55
);

    localparam int DIV_W = (CEN_DIV > 1) ? $clog2(CEN_DIV) : 1;
    localparam int SUB_W = (CEN55_DIV > 1) ? $clog2(CEN55_DIV) : 1;

    logic [DIV_W-1:0] div_cnt;  // clocks within one cen period
    logic [SUB_W-1:0] sub_cnt;  // cens within one cen55 period

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            div_cnt <= '0;
            sub_cnt <= '0;
        end else begin
            div_cnt <= (div_cnt == DIV_W'(CEN_DIV - 1)) ? '0 : div_cnt + 1'b1;
            if (cen) begin  // sub counter only moves on cen
                sub_cnt <= (sub_cnt == SUB_W'(CEN55_DIV - 1)) ? '0 : sub_cnt + 1'b1;
            end
        end
    end

    assign cen   = (div_cnt == '0);
    assign cen55 = cen && (sub_cnt == '0);  // aligned to a cen

    // both counters wrap together, one cen55 per CEN_DIV * CEN55_DIV clocks
    a_cen55_period: assert property (@(posedge clk) disable iff (!arst_n)
        cen55 |=> !cen55 [* (CEN_DIV * CEN55_DIV - 1)] ##1 cen55);

endmodule

// File: adpcmb_seq_if.sv
// ------------------------------------------------------------
// sequencer to datapath link
// fetch strobe level, nibble select, byte address
// and the top byte of the phase accumulator
// ------------------------------------------------------------
interface adpcmb_seq_if;

    logic              adv;         // phase carry, valid on the cen55 cycle
    logic              nibble_sel;  // 0 high nibble, 1 low nibble
    adpcmb_pkg::addr_t addr;        // byte to read
    logic [7:0]        phase_frac;  // position between two samples

    // counter side
    modport cnt (output adv, nibble_sel, addr, phase_frac);

    // datapath side
    modport dp (input adv, nibble_sel, addr, phase_frac);

endinterface

// File: adpcmb_pkg.sv
// ------------------------------------------------------------
// shared definitions for the ADPCM-B channel
// vector typedefs for addresses, pages, samples and gain
// decoder step limits and step multiplier table
// counter state enum
// ------------------------------------------------------------
package adpcmb_pkg;

    typedef logic [23:0]        addr_t;    // byte address into sample memory
    typedef logic [15:0]        page_t;    // 256-byte page, addr = page * 256
    typedef logic [15:0]        delta_t;   // delta-N phase increment
    typedef logic signed [15:0] pcm_t;     // signed sample
    typedef logic [3:0]         nibble_t;  // ADPCM code, bit 3 is the sign
    typedef logic [7:0]         tl_t;      // total level
    typedef logic [15:0]        step_t;    // adaptive step size

    // step size limits
    localparam step_t STEP_MIN = 16'd127;
    localparam step_t STEP_MAX = 16'd24576;

    // saturation limits of the decoded sample
    localparam pcm_t PCM_MAX = 16'sh7fff;
    localparam pcm_t PCM_MIN = 16'sh8000;

    // step multiplier per code magnitude, in 64ths
    localparam logic [7:0] step_scale [8] = '{
        8'd57, 8'd57, 8'd57, 8'd57,    // small codes shrink the step
        8'd77, 8'd102, 8'd128, 8'd153  // large codes grow it
    };

    typedef enum logic [1:0] {
        IDLE,  // waiting for key on
        PLAY,  // fetching nibbles
        DONE   // end of a non-repeating sample
    } cnt_state_e;

endpackage
